// File: Makefile
# Verilator build and run of the core pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_core_pipe
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: core_pipe.sv
// Five-stage pipeline top level
// IF/ID/EX/MEM/WB stage registers, stage units and hazard unit on plain ports

`timescale 1ns/10ps

module core_pipe import core_pkg::*; #(
    parameter int MULDIV_CYCLES = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    // Fetch source
    input  logic               fetch_valid,
    input  logic [PC_W-1:0]    fetch_pc,
    input  logic [INSTR_W-1:0] fetch_instr,
    output logic               fetch_ready,
    // Redirect to fetch, always accepted
    output logic               redirect_valid,
    output logic [PC_W-1:0]    redirect_pc,
    // Data bus
    output logic               dbus_valid,
    output logic [PC_W-1:0]    dbus_addr,
    input  logic               dbus_ready,
    // Retirement
    output logic               retire_valid,
    output logic [PC_W-1:0]    retire_pc
);

    hazard_req_if req_if ();
    hazard_ctl_if ctl_if ();

    fetch_t          if_tok;
    fetch_t          id_tok;
    logic            id_valid;
    uop_t            id_uop;
    uop_t            ex_uop;
    logic            ex_valid;
    uop_t            mem_uop;
    logic            mem_valid;
    uop_t            wb_uop;
    logic            wb_valid;
    logic [PC_W-1:0] branch_target;

    assign if_tok      = '{pc: fetch_pc, word: fetch_instr};
    assign fetch_ready = ~ctl_if.if_stall;

    // --------------------
    // Stage registers
    // --------------------

    pipe_stage #(.payload_t(fetch_t)) u_if_id (
        .clk(clk), .rst_n(rst_n),
        .stall(ctl_if.if_stall), .flush(ctl_if.if_flush), .bubble(1'b0),
        .in_valid(fetch_valid), .in_data(if_tok),
        .out_valid(id_valid), .out_data(id_tok)
    );

    pipe_stage #(.payload_t(uop_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n),
        .stall(ctl_if.id_stall), .flush(ctl_if.id_flush), .bubble(ctl_if.id_bubble),
        .in_valid(id_valid), .in_data(id_uop),
        .out_valid(ex_valid), .out_data(ex_uop)
    );

    pipe_stage #(.payload_t(uop_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n),
        .stall(ctl_if.ex_stall), .flush(ctl_if.ex_flush), .bubble(ctl_if.ex_bubble),
        .in_valid(ex_valid), .in_data(ex_uop),
        .out_valid(mem_valid), .out_data(mem_uop)
    );

    pipe_stage #(.payload_t(uop_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n),
        .stall(ctl_if.mem_stall), .flush(ctl_if.mem_flush), .bubble(1'b0),
        .in_valid(mem_valid), .in_data(mem_uop),
        .out_valid(wb_valid), .out_data(wb_uop)
    );

    // --------------------
    // Stage units
    // --------------------

    id_decode u_id_decode (
        .fetch_in(id_tok), .fetch_in_valid(id_valid), .uop(id_uop),
        .ex_uop(ex_uop), .ex_valid(ex_valid), .req(req_if.src)
    );

    ex_unit #(.MULDIV_CYCLES(MULDIV_CYCLES)) u_ex_unit (
        .clk(clk), .rst_n(rst_n),
        .uop(ex_uop), .valid(ex_valid), .stall(ctl_if.ex_stall),
        .req(req_if.src), .branch_target(branch_target)
    );

    mem_wb_unit u_mem_wb_unit (
        .mem_uop(mem_uop), .mem_valid(mem_valid),
        .wb_uop(wb_uop), .wb_valid(wb_valid), .wb_stall(ctl_if.wb_stall),
        .dbus_ready(dbus_ready),
        .branch_take(req_if.branch_take), .branch_target(branch_target),
        .dbus_valid(dbus_valid), .dbus_addr(dbus_addr), .req(req_if.src),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    hdu u_hdu (
        .req(req_if.hdu),
        .ctl(ctl_if.hdu)
    );

endmodule

// File: core_pipe_cases.txt
// Case header: words fetch_density dbus_density step_limit retires (hex, density out of 10)
// Then address/word pairs, word is kind rd rs1 rs2; a header word of 0 ends the list
5 10 10 10 5
00 0123 01 0234 02 0345 03 0456 04 0567
7 10 10 14 7
00 1110 01 0212 02 1320 03 0445 04 2034 05 1500 06 0655
7 10 10 14 7
00 3712 01 0877 02 4900 03 4a90 04 1b00 05 3cbb 06 0dcc
d 10 10 20 a
00 0111 01 5004 02 0222 03 0333 04 0444 05 6001 06 0555
07 1600 08 5002 09 5003 0a 0777 0b 50fe 0c 0888
8 10 10 10 4
00 0111 01 7000 02 0222 03 5004 c0 0333 c1 5002 c2 0444 c3 0555
5 8 5 10 5
00 0123 01 0234 02 0345 03 0456 04 0567
7 9 6 14 7
00 1110 01 0212 02 1320 03 0445 04 2034 05 1500 06 0655
7 a 7 14 7
00 3712 01 0877 02 4900 03 4a90 04 1b00 05 3cbb 06 0dcc
d b 5 20 a
00 0111 01 5004 02 0222 03 0333 04 0444 05 6001 06 0555
07 1600 08 5002 09 5003 0a 0777 0b 50fe 0c 0888
8 7 6 10 4
00 0111 01 7000 02 0222 03 5004 c0 0333 c1 5002 c2 0444 c3 0555
0

// File: core_pkg.sv
// Core pipeline package
// Field widths, instruction kinds and stage payloads shared across the pipeline

package core_pkg;

    // --------------------
    // Field widths
    // --------------------

    // Instruction address
    parameter int PC_W    = 8;
    // Register number
    parameter int REG_W   = 4;
    parameter int KIND_W  = 4;
    // Kind, rd, rs1, rs2
    parameter int INSTR_W = KIND_W + 3 * REG_W;

    // Fetch target after a trap
    parameter logic [PC_W-1:0] TRAP_VEC = 8'hc0;

    // --------------------
    // Instruction word
    // --------------------

    typedef enum logic [KIND_W-1:0] {
        KIND_ALU       = 4'd0,
        KIND_LOAD      = 4'd1,
        KIND_STORE     = 4'd2,
        KIND_MULDIV    = 4'd3,
        KIND_CSR       = 4'd4,
        // Taken branch, redirects from EX
        KIND_BRANCH    = 4'd5,
        // Not-taken branch, falls through
        KIND_BRANCH_NT = 4'd6,
        KIND_TRAP      = 4'd7
    } instr_kind_e;

    // Branch offset is {rs1, rs2}, signed
    typedef struct packed {
        instr_kind_e      kind;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
    } instr_t;

    // --------------------
    // Stage payloads
    // --------------------

    // IF/ID token
    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] word;
    } fetch_t;

    // ID/EX, EX/MEM and MEM/WB token
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        instr_kind_e      kind;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic             uses_rs1;
        logic             uses_rs2;
    } uop_t;

endpackage

// File: ex_unit.sv
// Execute stage unit
// Branch resolution, multi-cycle muldiv timing and CSR detection in EX

`timescale 1ns/10ps

module ex_unit import core_pkg::*; #(
    parameter int MULDIV_CYCLES = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  uop_t            uop,
    input  logic            valid,
    input  logic            stall,
    hazard_req_if.src       req,
    output logic [PC_W-1:0] branch_target
);

    // Wide enough to hold MULDIV_CYCLES-1, at least one bit
    localparam int               CNT_W    = $clog2(MULDIV_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MULDIV_CYCLES - 1);

    logic [CNT_W-1:0] md_cnt;
    logic             md_busy;
    logic [PC_W-1:0]  offset;

    // --------------------
    // Muldiv
    // --------------------

    // Stall until the last cycle, then let it advance
    assign md_busy = valid && (uop.kind == KIND_MULDIV) && (md_cnt != CNT_LAST);

    // Counter back to zero as the op leaves or when EX is empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_cnt <= '0;
        end else if (!stall) begin
            if (md_busy) begin
                md_cnt <= md_cnt + 1'b1;
            end else begin
                md_cnt <= '0;
            end
        end
    end

    assign req.muldiv_stall_req = md_busy;

    // --------------------
    // Branch and CSR
    // --------------------

    // Offset is {rs1, rs2}, sign extended
    assign offset        = PC_W'($signed({uop.rs1, uop.rs2}));
    assign branch_target = uop.pc + offset;

    // branch_nt falls through with no redirect
    assign req.branch_take = valid && (uop.kind == KIND_BRANCH);
    assign req.ex_csr_read = valid && (uop.kind == KIND_CSR);

endmodule

// File: hdu.sv
// Hazard detection unit
// Arbitrates stall and flush causes into per-stage register controls, zero latency

`timescale 1ns/10ps

module hdu (
    hazard_req_if.hdu req,
    hazard_ctl_if.hdu ctl
);

    // Any CSR still ahead of WB
    logic csr_stall;
    // Taken branch allowed to act this cycle
    logic branch_flush;
    // Whole pipeline frozen
    logic freeze;

    // --------------------
    // Cause merging
    // --------------------

    // Only one CSR in flight at a time, the next waits in ID
    assign csr_stall    = req.ex_csr_read | req.mem_csr_read;
    assign freeze       = req.lsu_dbus_busy;

    // Branch waits in EX while the bus holds MEM
    assign branch_flush = req.branch_take & ~freeze;

    // --------------------
    // Flushes
    // --------------------

    // Wrong-path tokens sit in IF and ID behind the branch
    assign ctl.if_flush  = branch_flush | req.trap_take;
    assign ctl.id_flush  = branch_flush | req.trap_take;
    // Trap in WB kills everything younger
    assign ctl.ex_flush  = req.trap_take;
    assign ctl.mem_flush = req.trap_take;

    // --------------------
    // Bubbles
    // --------------------

    // Hold ID token, send empty slot to EX
    // Not while frozen, EX must keep its token
    assign ctl.id_bubble = ~freeze & (csr_stall | req.load_stall_req);
    // Muldiv stays in EX, MEM gets an empty slot
    assign ctl.ex_bubble = req.muldiv_stall_req;

    // --------------------
    // Stalls
    // --------------------

    assign ctl.if_stall  = freeze | req.load_stall_req | csr_stall | req.muldiv_stall_req;
    assign ctl.id_stall  = freeze | req.muldiv_stall_req;
    assign ctl.ex_stall  = freeze;
    assign ctl.mem_stall = freeze;
    assign ctl.wb_stall  = freeze;

endmodule

// File: hdu_if.sv
// Hazard unit interfaces
// Requests raised by the stages and controls returned to the stage registers

`timescale 1ns/10ps

// Stall and flush causes, one driver per signal
interface hazard_req_if;
    logic lsu_dbus_busy;
    logic load_stall_req;
    logic muldiv_stall_req;
    logic ex_csr_read;
    logic mem_csr_read;
    logic branch_take;
    logic trap_take;

    // Stage units each drive their own subset
    modport src (
        output lsu_dbus_busy, load_stall_req, muldiv_stall_req,
        output ex_csr_read, mem_csr_read, branch_take, trap_take
    );
    modport hdu (
        input  lsu_dbus_busy, load_stall_req, muldiv_stall_req,
        input  ex_csr_read, mem_csr_read, branch_take, trap_take
    );
endinterface

// Per-stage register controls
interface hazard_ctl_if;
    logic if_flush, id_flush, ex_flush, mem_flush;
    logic if_stall, id_stall, ex_stall, mem_stall, wb_stall;
    logic id_bubble, ex_bubble;

    modport hdu (
        output if_flush, id_flush, ex_flush, mem_flush,
        output if_stall, id_stall, ex_stall, mem_stall, wb_stall,
        output id_bubble, ex_bubble
    );
    // Consumer view for the stage registers
    modport stage (
        input  if_flush, id_flush, ex_flush, mem_flush,
        input  if_stall, id_stall, ex_stall, mem_stall, wb_stall,
        input  id_bubble, ex_bubble
    );
endinterface

// File: id_decode.sv
// Instruction decode stage
// Splits fetched words into micro-ops and flags a load-use dependence on EX

`timescale 1ns/10ps

module id_decode import core_pkg::*; (
    input  fetch_t          fetch_in,
    input  logic            fetch_in_valid,
    output uop_t            uop,
    input  uop_t            ex_uop,
    input  logic            ex_valid,
    hazard_req_if.src       req
);

    instr_t word;
    // Load in EX that writes a real register
    logic   ex_load;
    logic   rs1_hit;
    logic   rs2_hit;

    assign word = instr_t'(fetch_in.word);

    // --------------------
    // Field split
    // --------------------

    always_comb begin
        uop.pc       = fetch_in.pc;
        uop.kind     = word.kind;
        uop.rd       = word.rd;
        uop.rs1      = word.rs1;
        uop.rs2      = word.rs2;
        uop.uses_rs1 = 1'b0;
        uop.uses_rs2 = 1'b0;
        case (word.kind)
            KIND_ALU, KIND_STORE, KIND_MULDIV: begin
                uop.uses_rs1 = 1'b1;
                uop.uses_rs2 = 1'b1;
            end
            // Address base or CSR source
            KIND_LOAD, KIND_CSR: begin
                uop.uses_rs1 = 1'b1;
            end
            // rs2 field is the low offset half here
            KIND_BRANCH, KIND_BRANCH_NT: begin
                uop.uses_rs1 = 1'b1;
            end
            // Trap and unknown kinds read nothing
            default: begin
                uop.uses_rs1 = 1'b0;
                uop.uses_rs2 = 1'b0;
            end
        endcase
    end

    // --------------------
    // Load-use check
    // --------------------

    // r0 never carries a dependence
    assign ex_load = ex_valid && (ex_uop.kind == KIND_LOAD) && (ex_uop.rd != '0);
    assign rs1_hit = uop.uses_rs1 && (uop.rs1 == ex_uop.rd);
    assign rs2_hit = uop.uses_rs2 && (uop.rs2 == ex_uop.rd);

    // One bubble, next cycle the load sits in MEM
    assign req.load_stall_req = ex_load && fetch_in_valid && (rs1_hit || rs2_hit);

endmodule

// File: mem_wb_unit.sv
// Memory and writeback unit
// Data bus request in MEM, retirement and trap redirect in WB

`timescale 1ns/10ps

module mem_wb_unit import core_pkg::*; (
    input  uop_t            mem_uop,
    input  logic            mem_valid,
    input  uop_t            wb_uop,
    input  logic            wb_valid,
    input  logic            wb_stall,
    input  logic            dbus_ready,
    input  logic            branch_take,
    input  logic [PC_W-1:0] branch_target,
    output logic            dbus_valid,
    output logic [PC_W-1:0] dbus_addr,
    hazard_req_if.src       req,
    output logic            retire_valid,
    output logic [PC_W-1:0] retire_pc,
    output logic            redirect_valid,
    output logic [PC_W-1:0] redirect_pc
);

    logic dbus_busy;
    logic trap;

    // --------------------
    // MEM stage
    // --------------------

    // pc stands in for the data address
    assign dbus_valid = mem_valid && (mem_uop.kind == KIND_LOAD || mem_uop.kind == KIND_STORE);
    assign dbus_addr  = mem_uop.pc;

    // Busy until ready completes the request
    assign dbus_busy         = dbus_valid && !dbus_ready;
    assign req.lsu_dbus_busy = dbus_busy;
    assign req.mem_csr_read  = mem_valid && (mem_uop.kind == KIND_CSR);

    // --------------------
    // WB stage
    // --------------------

    assign trap          = wb_valid && (wb_uop.kind == KIND_TRAP);
    assign req.trap_take = trap;

    // Held token retires once, on the cycle it is released
    assign retire_valid = wb_valid && !trap && !wb_stall;
    assign retire_pc    = wb_uop.pc;

    // --------------------
    // Redirect
    // --------------------

    // Trap beats branch, branch waits out a busy bus
    assign redirect_valid = trap || (branch_take && !dbus_busy);
    assign redirect_pc    = trap ? TRAP_VEC : branch_target;

endmodule

// File: pipe_stage.sv
// Pipeline stage register
// One token plus valid bit, priority flush over stall over bubble over load

`timescale 1ns/10ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     bubble,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // --------------------
    // Valid bit
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            // Bubble drops the incoming token
            out_valid <= in_valid & ~bubble;
        end
    end

    // --------------------
    // Payload
    // --------------------

    // Only real tokens are captured, bubbles leave data untouched
    always_ff @(posedge clk) begin
        if (!stall && !bubble && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// File: tb_core_pipe.sv
// Core pipeline testbench
// Fetch and data bus models, reference program walk, retire and redirect checks

`timescale 1ns/10ps

module tb_core_pipe
    import core_pkg::*;
();

    localparam int MULDIV_CYCLES = 4;
    localparam int CLK_PERIOD    = 4;
    localparam int CASE_WORDS    = 512;
    localparam int PC_SPAN       = 1 << PC_W;

    logic               clk;
    logic               rst_n;
    logic               fetch_valid;
    logic [PC_W-1:0]    fetch_pc;
    logic [INSTR_W-1:0] fetch_instr;
    logic               fetch_ready;
    logic               redirect_valid;
    logic [PC_W-1:0]    redirect_pc;
    logic               dbus_valid;
    logic [PC_W-1:0]    dbus_addr;
    logic               dbus_ready;
    logic               retire_valid;
    logic [PC_W-1:0]    retire_pc;

    // Case file image and the program of the current case
    logic [15:0]        cases_mem [0:CASE_WORDS-1];
    logic [INSTR_W-1:0] prog_word [0:PC_SPAN-1];
    logic               prog_ok   [0:PC_SPAN-1];

    // Expected sequences from the reference walk
    logic [PC_W-1:0]    exp_ret[$];
    logic [PC_W-1:0]    exp_redir[$];

    logic [31:0]        lfsr;
    // Fetch source pc, and an offer not yet taken
    logic [PC_W-1:0]    fpc;
    logic               held;
    // Address of the last completed data bus request
    logic [PC_W-1:0]    bus_pc;
    // Densities out of 16
    logic [4:0]         fetch_dens;
    logic [4:0]         dbus_dens;
    int                 ret_idx;
    int                 redir_idx;
    int                 n_checks;
    int                 n_errors;
    int                 wd_cycles;

    core_pipe #(.MULDIV_CYCLES(MULDIV_CYCLES)) dut (
        .clk(clk), .rst_n(rst_n),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
        .fetch_ready(fetch_ready),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .dbus_valid(dbus_valid), .dbus_addr(dbus_addr), .dbus_ready(dbus_ready),
        .retire_valid(retire_valid), .retire_pc(retire_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // Random source
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic logic [3:0] draw_nibble();
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[2:0], lfsr[0]};
        end
        return r;
    endfunction

    // --------------------
    // Checks
    // --------------------

    task automatic check_pc(input logic [PC_W-1:0] got, input logic [PC_W-1:0] want,
                            input string what);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("** Error at %0t ns: %s pc %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        n_checks++;
        if (got != want) begin
            n_errors++;
            $display("** Error at %0t ns: %s %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // Architectural walk, builds the expected retire and redirect lists
    task automatic walk_program(input int limit);
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] w;
        int                 steps;
        pc    = '0;
        steps = 0;
        exp_ret.delete();
        exp_redir.delete();
        while (prog_ok[pc] && steps < limit) begin
            w = prog_word[pc];
            steps++;
            if (w[15:12] == KIND_BRANCH) begin
                exp_ret.push_back(pc);
                // Signed 8-bit offset, wraps with the pc
                pc = pc + w[7:0];
                exp_redir.push_back(pc);
            end else if (w[15:12] == KIND_TRAP) begin
                // Trap never retires
                pc = TRAP_VEC;
                exp_redir.push_back(pc);
            end else begin
                // branch_nt falls through like the rest
                exp_ret.push_back(pc);
                pc = pc + 1'b1;
            end
        end
        if (prog_ok[pc]) begin
            n_errors++;
            $display("Reference walk ran past its step limit of %0d", limit);
        end
    endtask

    // --------------------
    // Bus models
    // --------------------

    // Settled outputs just ahead of the rising edge
    task automatic sample_outputs();
        logic [3:0] kind;
        if (retire_valid) begin
            if (ret_idx < exp_ret.size()) begin
                check_pc(retire_pc, exp_ret[ret_idx], "retire");
                // Loads and stores finish one bus request before leaving MEM
                kind = prog_word[exp_ret[ret_idx]][15:12];
                if (kind == KIND_LOAD || kind == KIND_STORE) begin
                    check_pc(bus_pc, exp_ret[ret_idx], "data bus");
                end
            end else begin
                n_errors++;
                $display("Extra retirement of pc %h at %0t ns", retire_pc, $time);
            end
            ret_idx++;
        end
        if (redirect_valid) begin
            if (redir_idx < exp_redir.size()) begin
                check_pc(redirect_pc, exp_redir[redir_idx], "redirect");
            end else begin
                n_errors++;
                $display("Extra redirect to pc %h at %0t ns", redirect_pc, $time);
            end
            redir_idx++;
        end
        // Only loads and stores use the data bus
        if (dbus_valid) begin
            kind = prog_word[dbus_addr][15:12];
            if (kind != KIND_LOAD && kind != KIND_STORE) begin
                n_errors++;
                $display("Data bus request from pc %h, which holds no load or store, at %0t ns",
                         dbus_addr, $time);
            end
            if (dbus_ready) begin
                bus_pc = dbus_addr;
            end
        end
        // Redirect wins over a handshake in the same cycle
        held = 1'b0;
        if (redirect_valid) begin
            fpc = redirect_pc;
        end else if (fetch_valid && fetch_ready) begin
            fpc = fpc + 1'b1;
        end else begin
            held = fetch_valid;
        end
    endtask

    // Inputs at the falling edge
    task automatic drive_inputs();
        logic [3:0] r_fetch;
        logic [3:0] r_bus;
        r_fetch = draw_nibble();
        r_bus   = draw_nibble();
        // Pending offer stays up, gaps only between offers
        if (!held) begin
            fetch_valid = prog_ok[fpc] && ({1'b0, r_fetch} < fetch_dens);
        end
        fetch_pc    = fpc;
        fetch_instr = prog_word[fpc];
        dbus_ready  = {1'b0, r_bus} < dbus_dens;
    endtask

    // Sample a quarter period before the rising edge, drive at the falling edge
    task automatic step_cycle();
        #(CLK_PERIOD / 4);
        sample_outputs();
        @(negedge clk);
        drive_inputs();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        int              ptr;
        int              n_words;
        int              limit;
        int              exp_n;
        int              n_cases;
        int              sum;
        logic [PC_W-1:0] at;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_instr = '0;
        dbus_ready  = 1'b0;
        lfsr        = 32'hf30a_ce03;
        fpc         = '0;
        held        = 1'b0;
        bus_pc      = '1;
        fetch_dens  = '0;
        dbus_dens   = '0;
        ret_idx     = 0;
        redir_idx   = 0;
        n_checks    = 0;
        n_errors    = 0;
        n_cases     = 0;
        $readmemh("core_pipe_cases.txt", cases_mem);

        // Watchdog budget from all step limits
        ptr = 0;
        sum = 0;
        while (cases_mem[ptr] != 16'h0) begin
            sum = sum + 32'(cases_mem[ptr+3]);
            ptr = ptr + 5 + 2 * 32'(cases_mem[ptr]);
        end
        wd_cycles = sum * (MULDIV_CYCLES + 8);

        ptr = 0;
        while (cases_mem[ptr] != 16'h0) begin
            n_words    = 32'(cases_mem[ptr]);
            fetch_dens = cases_mem[ptr+1][4:0];
            dbus_dens  = cases_mem[ptr+2][4:0];
            limit      = 32'(cases_mem[ptr+3]);
            exp_n      = 32'(cases_mem[ptr+4]);
            ptr        = ptr + 5;
            // Unloaded words tagged with their own address, never offered
            for (int addr = 0; addr < PC_SPAN; addr++) begin
                prog_ok[addr]   = 1'b0;
                prog_word[addr] = {8'h00, addr[7:0]};
            end
            for (int i = 0; i < n_words; i++) begin
                at            = cases_mem[ptr][PC_W-1:0];
                prog_word[at] = cases_mem[ptr+1];
                prog_ok[at]   = 1'b1;
                ptr           = ptr + 2;
            end
            walk_program(limit);
            check_count(exp_ret.size(), exp_n, "walk retire count");

            // Fresh pipeline for every case
            @(negedge clk);
            rst_n       = 1'b0;
            fetch_valid = 1'b0;
            dbus_ready  = 1'b0;
            repeat (3) @(negedge clk);
            rst_n     = 1'b1;
            fpc       = '0;
            held      = 1'b0;
            bus_pc    = '1;
            ret_idx   = 0;
            redir_idx = 0;
            drive_inputs();
            while (ret_idx < exp_ret.size()) begin
                step_cycle();
            end
            // Drain, late duplicates would show here
            repeat (MULDIV_CYCLES + 8) step_cycle();
            check_count(ret_idx, exp_n, "retire count");
            check_count(redir_idx, exp_redir.size(), "redirect count");
            n_cases++;
        end

        if (n_cases == 0) begin
            n_errors++;
            $display("No test cases were read from the case file");
        end
        $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the pipeline stopped retiring", wd_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: verilog.f
core_pkg.sv
hdu_if.sv
hdu.sv
pipe_stage.sv
id_decode.sv
ex_unit.sv
mem_wb_unit.sv
core_pipe.sv
tb_core_pipe.sv
